// File: rtl/lbp_params.svh
/*
  Fixed sizes of the local branch predictor. The history length also sets the
  counter table depth (2**LBP_HIST_BITS). LBP_HIST_ROWS must be a power of two.
*/
`ifndef LBP_PARAMS_SVH
`define LBP_PARAMS_SVH

// --------------------------------------------------
// PC geometry
// --------------------------------------------------

// Width of the virtual fetch PC
`define LBP_PC_WIDTH 32

// Low PC bits skipped when indexing (compressed instructions)
`define LBP_PC_OFFSET 1

// --------------------------------------------------
// Table sizes
// --------------------------------------------------

// Local history rows, indexed by PC
`define LBP_HIST_ROWS 64

// Outcomes kept per row, newest in bit 0
`define LBP_HIST_BITS 6

`endif

// File: rtl/lbp_pkg.sv
/*
  Types shared by the predictor tables. Sizes come from lbp_params.svh.
  The taken prediction is the top bit of the counter state.
*/
`include "lbp_params.svh"

package lbp_pkg;

  // --------------------------------------------------
  // Address types
  // --------------------------------------------------

  // Virtual fetch PC
  typedef logic [`LBP_PC_WIDTH-1:0] pc_t;

  // History row index, cut from the PC above the offset bits
  typedef logic [$clog2(`LBP_HIST_ROWS)-1:0] row_t;

  // Local history, also the counter table address
  typedef logic [`LBP_HIST_BITS-1:0] hist_t;

  // --------------------------------------------------
  // Counter state
  // --------------------------------------------------

  // 2-bit saturating counter, MSB set means taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'd0,
    WEAK_NT   = 2'd1,
    WEAK_T    = 2'd2,
    STRONG_T  = 2'd3
  } ctr_state_e;

endpackage

// File: rtl/lbp_history_table.sv
/*
  Local history storage, one shift register per PC row.
  Lookup is combinational; an update written at an edge is seen from the
  next cycle on. Flush does not touch the histories.
*/
`timescale 1ns/1ps

`include "lbp_params.svh"

module lbp_history_table
  import lbp_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  // Update suppression while the core is halted in debug
  input  logic  debug_mode_i,
  // Fetch side lookup
  input  pc_t   vpc_i,
  // Resolved branch from execute
  input  logic  update_valid_i,
  input  pc_t   update_pc_i,
  input  logic  update_taken_i,
  // To the counter table
  output hist_t lookup_hist_o,
  output logic  ctr_we_o
);

  hist_t hist_q [`LBP_HIST_ROWS];

  row_t lookup_row;
  row_t update_row;
  logic update_accept;

  // --------------------------------------------------
  // Row selection
  // --------------------------------------------------

  // Bit 0 is never set for aligned instructions
  assign lookup_row = vpc_i[`LBP_PC_OFFSET +: $bits(row_t)];
  assign update_row = update_pc_i[`LBP_PC_OFFSET +: $bits(row_t)];

  // --------------------------------------------------
  // Lookup
  // --------------------------------------------------

  // Same-cycle updates are not forwarded
  assign lookup_hist_o = hist_q[lookup_row];

  // --------------------------------------------------
  // Update gating
  // --------------------------------------------------

  // Debug mode blocks both tables, only tested here
  assign update_accept = update_valid_i && !debug_mode_i;
  assign ctr_we_o      = update_accept;

  // --------------------------------------------------
  // History shift
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `LBP_HIST_ROWS; i++) begin
        hist_q[i] <= '0;
      end
    end else if (update_accept) begin
      // Newest outcome enters at bit 0, oldest drops off the top
      hist_q[update_row] <= {hist_q[update_row][`LBP_HIST_BITS-2:0], update_taken_i};
    end
  end

endmodule

// File: rtl/lbp_counter_table.sv
/*
  Pattern table of 2-bit saturating counters, addressed by local history.
  Flush wins over a write in the same cycle and leaves every entry WEAK_T
  and invalid. Reads are combinational with no write forwarding.
*/
`timescale 1ns/1ps

`include "lbp_params.svh"

module lbp_counter_table
  import lbp_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  // Evict all counters
  input  logic  flush_bp_i,
  // Prediction address from the history table
  input  hist_t lookup_hist_i,
  // Gated update strobe from the history table
  input  logic  ctr_we_i,
  // History saved at fetch time for this branch
  input  hist_t update_index_i,
  input  logic  update_taken_i,
  output logic  pred_valid_o,
  output logic  pred_taken_o
);

  localparam int unsigned NrEntries = 1 << `LBP_HIST_BITS;

  logic       valid_q [NrEntries];
  ctr_state_e ctr_q   [NrEntries];

  ctr_state_e lookup_state;
  ctr_state_e upd_state;
  ctr_state_e upd_state_next;

  // --------------------------------------------------
  // Prediction read
  // --------------------------------------------------

  assign lookup_state = ctr_q[lookup_hist_i];
  assign pred_valid_o = valid_q[lookup_hist_i];
  // Upper half of the state range predicts taken
  assign pred_taken_o = lookup_state inside {WEAK_T, STRONG_T};

  // --------------------------------------------------
  // Saturating step
  // --------------------------------------------------

  assign upd_state = ctr_q[update_index_i];

  always_comb begin
    unique case (upd_state)
      STRONG_NT: upd_state_next = update_taken_i ? WEAK_NT  : STRONG_NT;
      WEAK_NT:   upd_state_next = update_taken_i ? WEAK_T   : STRONG_NT;
      WEAK_T:    upd_state_next = update_taken_i ? STRONG_T : WEAK_NT;
      STRONG_T:  upd_state_next = update_taken_i ? STRONG_T : WEAK_T;
      default:   upd_state_next = STRONG_NT;
    endcase
  end

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NrEntries; i++) begin
        valid_q[i] <= 1'b0;
        ctr_q[i]   <= STRONG_NT;
      end
    end else if (flush_bp_i) begin
      // Weakly taken so the first outcome after a flush decides
      for (int i = 0; i < NrEntries; i++) begin
        valid_q[i] <= 1'b0;
        ctr_q[i]   <= WEAK_T;
      end
    end else if (ctr_we_i) begin
      valid_q[update_index_i] <= 1'b1;
      ctr_q[update_index_i]   <= upd_state_next;
    end
  end

endmodule

// File: rtl/lbp_top.sv
/*
  Two-level local branch predictor, one prediction per fetch.
  Prediction is combinational from vpc_i. The fetch side must keep index_o
  and return it on update_index_i when the branch resolves.
*/
`timescale 1ns/1ps

`include "lbp_params.svh"

module lbp_top
  import lbp_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_bp_i,
  input  logic  debug_mode_i,
  // Fetch PC
  input  pc_t   vpc_i,
  // Resolved branch
  input  logic  update_valid_i,
  input  pc_t   update_pc_i,
  input  logic  update_taken_i,
  input  hist_t update_index_i,
  // Prediction for vpc_i
  output logic  pred_valid_o,
  output logic  pred_taken_o,
  output hist_t index_o
);

  hist_t lookup_hist;
  logic  ctr_we;

  // History lookup is also the index saved by fetch
  assign index_o = lookup_hist;

  // --------------------------------------------------
  // First level, per-PC history
  // --------------------------------------------------

  lbp_history_table u_history (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .debug_mode_i   (debug_mode_i),
    .vpc_i          (vpc_i),
    .update_valid_i (update_valid_i),
    .update_pc_i    (update_pc_i),
    .update_taken_i (update_taken_i),
    .lookup_hist_o  (lookup_hist),
    .ctr_we_o       (ctr_we)
  );

  // --------------------------------------------------
  // Second level, pattern counters
  // --------------------------------------------------

  lbp_counter_table u_counter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_bp_i     (flush_bp_i),
    .lookup_hist_i  (lookup_hist),
    .ctr_we_i       (ctr_we),
    .update_index_i (update_index_i),
    .update_taken_i (update_taken_i),
    .pred_valid_o   (pred_valid_o),
    .pred_taken_o   (pred_taken_o)
  );

endmodule

// File: tests/lbp_clk_gen.sv
/*
  Free-running 10 ns clock with an active-low reset held for two rising edges.
*/
`timescale 1ns/1ps

module lbp_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release shortly after the second edge, away from the sampling point
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// File: tests/lbp_chk.sv
/*
  Concurrent checks on lbp_top, attached by bind. All properties are
  disabled while rst_ni is low.
*/
`timescale 1ns/1ps

module lbp_chk
  import lbp_pkg::*;
(
  input logic  clk_i,
  input logic  rst_ni,
  input logic  flush_bp_i,
  input logic  debug_mode_i,
  input pc_t   vpc_i,
  input logic  pred_valid_i,
  input logic  pred_taken_i,
  input hist_t index_i
);

  int fail_cnt = 0;

  // Prediction is fully defined once out of reset
  pred_known_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$isunknown({pred_valid_i, pred_taken_i})
  ) else begin
    fail_cnt++;
    $error("prediction outputs are unknown after reset");
  end

  // A halted edge leaves both tables alone when fetch repeats its PC
  debug_gate_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (debug_mode_i && !flush_bp_i) ##1 $stable(vpc_i)
      |-> $stable({index_i, pred_valid_i, pred_taken_i})
  ) else begin
    fail_cnt++;
    $error("predictor state changed on an edge in debug mode");
  end

  // Every entry is invalid in the cycle after a flush
  flush_clear_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) flush_bp_i |=> !pred_valid_i
  ) else begin
    fail_cnt++;
    $error("prediction still valid one cycle after a flush");
  end

endmodule

bind lbp_top lbp_chk u_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .flush_bp_i   (flush_bp_i),
  .debug_mode_i (debug_mode_i),
  .vpc_i        (vpc_i),
  .pred_valid_i (pred_valid_o),
  .pred_taken_i (pred_taken_o),
  .index_i      (index_o)
);

// File: tests/lbp_tb.sv
/*
  Testbench for lbp_top. A model of histories and counters is stepped at each
  falling edge, after the DUT outputs for the current fetch PC are compared.
  Inputs change 1 ns after the rising edge.
*/
`timescale 1ns/1ps

`include "lbp_params.svh"

module lbp_tb
  import lbp_pkg::*;
();

  localparam int rand_cycles = 1500;
  // Directed tests stay under 200 cycles, doubling the random part leaves margin
  localparam int timeout_cycles = 2 * rand_cycles;
  localparam pc_t pc_a = 32'h8000_0124;
  localparam pc_t pc_b = 32'h0000_0a40;

  logic  clk;
  logic  rst_n;
  logic  flush_bp;
  logic  debug_mode;
  pc_t   vpc;
  logic  update_valid;
  pc_t   update_pc;
  logic  update_taken;
  hist_t update_index;
  logic  pred_valid;
  logic  pred_taken;
  hist_t index;

  // Model state, always one step ahead of the DUT between falling and rising edge
  hist_t       m_hist  [`LBP_HIST_ROWS];
  logic [1:0]  m_ctr   [1 << `LBP_HIST_BITS];
  logic        m_valid [1 << `LBP_HIST_BITS];

  int unsigned err_cnt;
  int unsigned cycle_cnt;
  logic [31:0] rng;

  lbp_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  lbp_top dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .flush_bp_i     (flush_bp),
    .debug_mode_i   (debug_mode),
    .vpc_i          (vpc),
    .update_valid_i (update_valid),
    .update_pc_i    (update_pc),
    .update_taken_i (update_taken),
    .update_index_i (update_index),
    .pred_valid_o   (pred_valid),
    .pred_taken_o   (pred_taken),
    .index_o        (index)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic int row_of(input pc_t pc);
    return int'((pc >> `LBP_PC_OFFSET) % `LBP_HIST_ROWS);
  endfunction

  function automatic void model_reset();
    for (int i = 0; i < `LBP_HIST_ROWS; i++) begin
      m_hist[i] = '0;
    end
    for (int i = 0; i < (1 << `LBP_HIST_BITS); i++) begin
      m_ctr[i]   = STRONG_NT;
      m_valid[i] = 1'b0;
    end
  endfunction

  // One clock edge of the predictor, from the inputs it samples
  function automatic void model_step(input logic flush, input logic dbg, input logic upd_v,
                                     input pc_t upd_pc, input logic taken, input hist_t idx);
    int row;
    row = row_of(upd_pc);
    if (upd_v && !dbg) begin
      m_hist[row] = {m_hist[row][`LBP_HIST_BITS-2:0], taken};
    end
    if (flush) begin
      for (int i = 0; i < (1 << `LBP_HIST_BITS); i++) begin
        m_ctr[i]   = WEAK_T;
        m_valid[i] = 1'b0;
      end
    end else if (upd_v && !dbg) begin
      m_valid[idx] = 1'b1;
      if (taken && m_ctr[idx] != STRONG_T) begin
        m_ctr[idx] = m_ctr[idx] + 2'd1;
      end else if (!taken && m_ctr[idx] != STRONG_NT) begin
        m_ctr[idx] = m_ctr[idx] - 2'd1;
      end
    end
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  // The update index is the model history of idx_pc as seen after this edge
  task automatic drive_cycle(input logic flush, input logic dbg, input pc_t fetch_pc,
                             input logic upd_v, input pc_t upd_pc, input logic taken,
                             input pc_t idx_pc);
    @(posedge clk);
    #1;
    flush_bp     = flush;
    debug_mode   = dbg;
    vpc          = fetch_pc;
    update_valid = upd_v;
    update_pc    = upd_pc;
    update_taken = taken;
    update_index = m_hist[row_of(idx_pc)];
  endtask

  task automatic drive_idle(input pc_t fetch_pc);
    drive_cycle(1'b0, 1'b0, fetch_pc, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic sweep_pcs();
    for (int i = 0; i < `LBP_HIST_ROWS; i++) begin
      drive_idle(pc_t'(i) << `LBP_PC_OFFSET);
    end
  endtask

  // --------------------------------------------------
  // Comparison and timeout
  // --------------------------------------------------

  always @(negedge clk) begin : compare
    hist_t exp_idx;
    if (rst_n === 1'b1) begin
      exp_idx = m_hist[row_of(vpc)];
      check_val("index_o", 32'(index), 32'(exp_idx));
      check_val("pred_valid_o", 32'(pred_valid), 32'(m_valid[exp_idx]));
      check_val("pred_taken_o", 32'(pred_taken), 32'(m_ctr[exp_idx][1]));
      model_step(flush_bp, debug_mode, update_valid, update_pc, update_taken, update_index);
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin : stimulus
    logic [9:0] pattern;
    hist_t      exp_hist;
    pc_t        upd_pc;
    pc_t        fetch_pc;
    err_cnt      = 0;
    rng          = 32'h852bb8a9;
    pattern      = 10'b1101001110;
    flush_bp     = 1'b0;
    debug_mode   = 1'b0;
    vpc          = '0;
    update_valid = 1'b0;
    update_pc    = '0;
    update_taken = 1'b0;
    update_index = '0;
    model_reset();
    wait (rst_n === 1'b1);

    // Reset state over all rows
    sweep_pcs();

    // History shift, newest outcome in bit 0
    for (int k = 0; k < 10; k++) begin
      drive_cycle(1'b0, 1'b0, pc_a, 1'b1, pc_a, pattern[k], pc_a);
    end
    drive_idle(pc_a);
    @(negedge clk);
    exp_hist = '0;
    for (int k = 10 - `LBP_HIST_BITS; k < 10; k++) begin
      exp_hist = {exp_hist[`LBP_HIST_BITS-2:0], pattern[k]};
    end
    check_val("index_o", 32'(index), 32'(exp_hist));

    // Saturation on the entry that pc_a looks up, histories move on pc_b only
    repeat (5) drive_cycle(1'b0, 1'b0, pc_a, 1'b1, pc_b, 1'b1, pc_a);
    repeat (5) drive_cycle(1'b0, 1'b0, pc_a, 1'b1, pc_b, 1'b0, pc_a);

    // Updates in debug mode are dropped
    for (int k = 0; k < 8; k++) begin
      rng = xorshift32(rng);
      drive_cycle(1'b0, 1'b1, pc_a, 1'b1, rng[1] ? pc_a : pc_b, rng[0], pc_a);
    end

    // Flush with an update in the same cycle, then look at every row
    drive_cycle(1'b1, 1'b0, pc_a, 1'b1, pc_a, 1'b1, pc_a);
    sweep_pcs();

    // Random mix
    for (int n = 0; n < rand_cycles; n++) begin
      rng      = xorshift32(rng);
      upd_pc   = rng;
      rng      = xorshift32(rng);
      fetch_pc = rng[0] ? upd_pc : rng;
      drive_cycle(rng[12:7] == 6'd0, rng[3:1] == 3'd0, fetch_pc,
                  rng[5:4] != 2'd0, upd_pc, rng[6], upd_pc);
    end

    drive_idle('0);
    @(negedge clk);
    #1;
    $display("Errors: %0d value mismatches, %0d assertion failures",
             err_cnt, dut.u_chk.fail_cnt);
    if (err_cnt == 0 && dut.u_chk.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: lbp.f
+incdir+rtl
rtl/lbp_pkg.sv
rtl/lbp_history_table.sv
rtl/lbp_counter_table.sv
rtl/lbp_top.sv
tests/lbp_clk_gen.sv
tests/lbp_chk.sv
tests/lbp_tb.sv

// File: run_lbp.sh
#!/bin/sh
# Build and run the local branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module lbp_tb \
  -f lbp.f \
  -o sim_lbp

# Assertion errors must not end the run before the summary line
./obj_dir/sim_lbp +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1
